/* bench/backendChecker.sv */
`timescale 1ns/10ps

module backendChecker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instValid,
    input  backendPkg::unitKind              instKind,
    input  logic [backendPkg::ARCH_BITS-1:0] instDest,
    input  logic                             instMispredict,
    input  logic                             instReady,
    input  logic                             aluIssueValid,
    input  logic [backendPkg::ROB_BITS-1:0]  aluIssueTag,
    input  logic                             lsuIssueValid,
    input  logic [backendPkg::ROB_BITS-1:0]  lsuIssueTag,
    input  logic                             mduIssueValid,
    input  logic [backendPkg::ROB_BITS-1:0]  mduIssueTag,
    input  logic                             commitValid,
    input  logic [backendPkg::ROB_BITS-1:0]  commitTag,
    input  logic [backendPkg::ARCH_BITS-1:0] commitDest,
    input  logic [backendPkg::PHYS_BITS-1:0] commitPhys,
    input  logic                             backendFlush,
    output int                               errorCount,
    output int                               inFlight,
    output int                               flushCount
);
    import backendPkg::*;

    // Intake register, dispatch register and a full ROB.
    localparam int MAX_IN_FLIGHT = ROB_DEPTH + 2;

    typedef struct packed {
        unitKind              kind;
        logic [ARCH_BITS-1:0] dest;
        logic                 mispredict;
        logic [ROB_BITS-1:0]  tag;
        logic                 issued;
        logic                 renamed;
        logic [PHYS_BITS-1:0] phys;
        logic [PHYS_BITS-1:0] oldPhys;
    } modelEntry;

    modelEntry            pending [$];
    logic [PHYS_BITS-1:0] specFree [$];
    logic [PHYS_BITS-1:0] commitFree [$];
    logic [PHYS_BITS-1:0] specTable [ARCH_REGS];
    logic [PHYS_BITS-1:0] commitTable [ARCH_REGS];
    logic [ROB_BITS-1:0]  nextTag;
    logic                 dropNext;
    logic                 wasRst;

    initial begin
        errorCount = 0;
        inFlight   = 0;
        flushCount = 0;
    end

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string text);
        $display("ERROR at %0t: %s", $time, text);
        errorCount++;
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================

    task automatic resetModel();
        pending.delete();
        specFree.delete();
        commitFree.delete();
        for (int r = 0; r < ARCH_REGS; r++) begin
            specTable[r]   = PHYS_BITS'(r);
            commitTable[r] = PHYS_BITS'(r);
        end
        for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
            specFree.push_back(PHYS_BITS'(i));
            commitFree.push_back(PHYS_BITS'(i));
        end
        nextTag  = '0;
        dropNext = 1'b0;
    endtask

    // Free registers leave in ring order, so allocation can run lazily.
    task automatic renamePending();
        modelEntry entry;
        for (int i = 0; i < pending.size(); i++) begin
            entry = pending[i];
            if (!entry.renamed) begin
                if (specFree.size() == 0) break;
                entry.phys            = specFree.pop_front();
                entry.oldPhys         = specTable[entry.dest];
                specTable[entry.dest] = entry.phys;
                entry.renamed         = 1'b1;
                pending[i]            = entry;
            end
        end
    endtask

    task automatic checkIssue(input unitKind kind, input logic valid,
                              input logic [ROB_BITS-1:0] tag, input string name);
        modelEntry entry;
        int        found;
        found = -1;
        if (valid) begin
            for (int i = 0; i < pending.size(); i++) begin
                if (found < 0 && !pending[i].issued && pending[i].kind == kind) found = i;
            end
            if (found < 0) begin
                reportProblem($sformatf("%s issued tag %0d with no instruction waiting",
                                        name, tag));
            end else begin
                entry = pending[found];
                compareValue(name, entry.tag, tag);
                entry.issued   = 1'b1;
                pending[found] = entry;
            end
        end
    endtask

    task automatic retireHead();
        modelEntry head;
        head = pending.pop_front();
        commitTable[head.dest] = head.phys;
        void'(commitFree.pop_front());
        commitFree.push_back(head.oldPhys);            // Old mapping returns to the ring.
        specFree.push_back(head.oldPhys);
        if (head.mispredict) begin
            flushCount++;
            pending.delete();
            specFree  = commitFree;
            specTable = commitTable;
            nextTag   = '0;
        end
    endtask

    task automatic acceptInst();
        modelEntry entry;
        entry            = '0;
        entry.kind       = instKind;
        entry.dest       = instDest;
        entry.mispredict = instMispredict;
        entry.tag        = nextTag;
        pending.push_back(entry);
        nextTag = nextTag + 1'b1;
    endtask

    // ========================================================================
    // Comparison, once per cycle while everything is stable
    // ========================================================================

    always @(negedge clk) begin
        modelEntry head;
        logic      flushNow;
        flushNow = 1'b0;
        if (rst || wasRst) compareValue("instReady", 1'b0, instReady);
        if (rst) begin
            compareValue("aluIssueValid", 1'b0, aluIssueValid);
            compareValue("lsuIssueValid", 1'b0, lsuIssueValid);
            compareValue("mduIssueValid", 1'b0, mduIssueValid);
            compareValue("commitValid", 1'b0, commitValid);
            compareValue("backendFlush", 1'b0, backendFlush);
            resetModel();
        end else begin
            renamePending();
            if (commitValid) begin
                if (pending.size() == 0) begin
                    reportProblem("commit seen with no instruction in flight");
                end else begin
                    head = pending[0];
                    if (!head.issued) begin
                        reportProblem($sformatf("tag %0d committed before it issued", commitTag));
                    end
                    compareValue("commitTag", head.tag, commitTag);
                    compareValue("commitDest", head.dest, commitDest);
                    compareValue("commitPhys", head.phys, commitPhys);
                    flushNow = head.mispredict;
                end
            end
            compareValue("backendFlush", flushNow, backendFlush);
            checkIssue(UNIT_ALU, aluIssueValid, aluIssueTag, "aluIssueTag");
            checkIssue(UNIT_LSU, lsuIssueValid, lsuIssueTag, "lsuIssueTag");
            checkIssue(UNIT_MDU, mduIssueValid, mduIssueTag, "mduIssueTag");
            if (commitValid && pending.size() != 0) retireHead();
            // Intake taken in the flush cycle or the one after is discarded.
            if (instValid && instReady && !flushNow && !dropNext) acceptInst();
            dropNext = flushNow;
            if (pending.size() > MAX_IN_FLIGHT) begin
                reportProblem("more instructions accepted than the backend can hold");
            end
        end
        wasRst   = rst;
        inFlight = pending.size();
    end

endmodule

/* bench/backendTb.sv */
`timescale 1ns/10ps

module backendTb;
    import backendPkg::*;

    localparam logic [31:0] SEED            = 32'hef5f;
    localparam int          INSTS_PER_TEST  = 48;
    localparam int          WATCHDOG_CYCLES = INSTS_PER_TEST * 4 * 40;
    localparam int          DRAIN_LIMIT     = 400;
    localparam int          HOLD_CYCLES     = 60;

    logic                 clk;
    logic                 rst;
    logic                 instValid;
    unitKind              instKind;
    logic [ARCH_BITS-1:0] instDest;
    logic                 instMispredict;
    logic                 instReady;
    logic                 aluExecReady, lsuExecReady, mduExecReady;
    logic                 aluIssueValid, lsuIssueValid, mduIssueValid;
    logic [ROB_BITS-1:0]  aluIssueTag, lsuIssueTag, mduIssueTag;
    logic                 commitValid;
    logic [ROB_BITS-1:0]  commitTag;
    logic [ARCH_BITS-1:0] commitDest;
    logic [PHYS_BITS-1:0] commitPhys;
    logic                 backendFlush;
    int                   errorCount, inFlight, flushCount;
    int                   benchErrors, testsRun, testsFailed;
    logic [31:0]          rngState;

    clockGen u_clockGen (.clk(clk), .rst(rst));

    backendTop u_backendTop (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instKind(instKind), .instDest(instDest),
        .instMispredict(instMispredict), .instReady(instReady),
        .aluExecReady(aluExecReady), .lsuExecReady(lsuExecReady),
        .mduExecReady(mduExecReady),
        .aluIssueValid(aluIssueValid), .aluIssueTag(aluIssueTag),
        .lsuIssueValid(lsuIssueValid), .lsuIssueTag(lsuIssueTag),
        .mduIssueValid(mduIssueValid), .mduIssueTag(mduIssueTag),
        .commitValid(commitValid), .commitTag(commitTag), .commitDest(commitDest),
        .commitPhys(commitPhys), .backendFlush(backendFlush)
    );

    backendChecker u_backendChecker (
        .clk(clk), .rst(rst),
        .instValid(instValid), .instKind(instKind), .instDest(instDest),
        .instMispredict(instMispredict), .instReady(instReady),
        .aluIssueValid(aluIssueValid), .aluIssueTag(aluIssueTag),
        .lsuIssueValid(lsuIssueValid), .lsuIssueTag(lsuIssueTag),
        .mduIssueValid(mduIssueValid), .mduIssueTag(mduIssueTag),
        .commitValid(commitValid), .commitTag(commitTag), .commitDest(commitDest),
        .commitPhys(commitPhys), .backendFlush(backendFlush),
        .errorCount(errorCount), .inFlight(inFlight), .flushCount(flushCount)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawExecReady(input logic holdLsu);
        aluExecReady <= rngState[1:0] != 2'b00;           // Ready three cycles in four.
        lsuExecReady <= !holdLsu && rngState[3:2] != 2'b00;
        mduExecReady <= rngState[5:4] != 2'b00;
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic runInsts(input int count, input int flagEvery, input int holdCycles,
                            input logic flagFirst);
        int   sent;
        int   cycles;
        logic taken;
        sent   = 0;
        cycles = 0;
        while (sent < count) begin
            @(negedge clk);
            taken = instValid && instReady;
            @(posedge clk);
            if (taken) sent++;
            cycles++;
            rngState = xorshift32(rngState);
            drawExecReady(cycles <= holdCycles);
            if (taken || !instValid) begin
                if (sent < count) begin
                    instValid      <= 1'b1;
                    instKind       <= unitKind'(2'(rngState[17:8] % 10'd3));
                    instDest       <= rngState[20:18];
                    instMispredict <= (flagFirst && sent == 0) ||
                                      (flagEvery > 0 && int'(rngState[31:24]) % flagEvery == 0);
                end else begin
                    instValid <= 1'b0;
                end
            end
        end
    endtask

    task automatic drainPipeline();
        int waited;
        waited = 0;
        while (inFlight != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            rngState = xorshift32(rngState);
            drawExecReady(1'b0);
            waited++;
        end
        repeat (4) @(posedge clk);                        // Covers a late flush window.
        if (inFlight != 0) begin
            $display("ERROR at %0t: %0d instructions never committed", $time, inFlight);
            benchErrors++;
        end
    endtask

    task automatic closeTest(input string name, input int errorsBefore);
        int found;
        found = errorCount + benchErrors - errorsBefore;
        testsRun++;
        if (found == 0) begin
            $display("test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", testsRun, name, found);
        end
    endtask

    // ========================================================================
    // Test sequence and watchdog
    // ========================================================================

    initial begin
        int mark;
        int flushesBefore;
        rngState       = SEED;
        instValid      = 1'b0;
        instKind       = UNIT_ALU;
        instDest       = '0;
        instMispredict = 1'b0;
        aluExecReady   = 1'b1;                            // Units ready, so only reset keeps issue low.
        lsuExecReady   = 1'b1;
        mduExecReady   = 1'b1;
        benchErrors    = 0;
        testsRun       = 0;
        testsFailed    = 0;

        @(negedge rst);
        repeat (2) @(posedge clk);
        closeTest("reset", 0);

        mark = errorCount + benchErrors;
        runInsts(INSTS_PER_TEST, 0, 0, 1'b0);
        drainPipeline();
        closeTest("commit order", mark);

        mark = errorCount + benchErrors;
        runInsts(INSTS_PER_TEST, 0, HOLD_CYCLES, 1'b0);   // LSU stalled at the start.
        drainPipeline();
        closeTest("back-pressure", mark);

        mark          = errorCount + benchErrors;
        flushesBefore = flushCount;
        runInsts(INSTS_PER_TEST, 8, 0, 1'b0);
        drainPipeline();
        if (flushCount == flushesBefore) begin
            $display("ERROR at %0t: no mispredicted instruction reached commit", $time);
            benchErrors++;
        end
        closeTest("flush", mark);

        mark          = errorCount + benchErrors;
        flushesBefore = flushCount;
        runInsts(INSTS_PER_TEST, 0, 0, 1'b1);
        drainPipeline();
        if (flushCount == flushesBefore) begin
            $display("ERROR at %0t: the flagged first instruction caused no flush", $time);
            benchErrors++;
        end
        closeTest("recovery", mark);

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
                 errorCount + benchErrors);
        if (testsFailed == 0 && errorCount + benchErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* bench/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                            // 4 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* files.f */
logic/backendPkg.sv
logic/backendCtrl.sv
logic/renameStage.sv
logic/issueQueue.sv
logic/reorderBuffer.sv
logic/backendTop.sv
bench/clockGen.sv
bench/backendChecker.sv
bench/backendTb.sv

/* logic/backendCtrl.sv */
`timescale 1ns/10ps

module backendCtrl (
    input  logic clk,
    input  logic rst,
    input  logic robFull,
    input  logic renamePauseReq,
    input  logic renameAllocatable,
    input  logic aluIqReady,
    input  logic lsuIqReady,
    input  logic mduIqReady,
    input  logic flushReq,
    output logic pauseIntake,
    output logic pauseRename,
    output logic pauseDispatch,
    output logic flushDly,
    output logic robFlush,
    output logic backendFlush
);

    logic queueBlocked;
    logic outOfReset;

    // ========================================================================
    // Pause combination
    // ========================================================================

    assign queueBlocked = !aluIqReady || !lsuIqReady || !mduIqReady;

    assign pauseIntake = robFull || renamePauseReq || queueBlocked ||
                         !renameAllocatable || !outOfReset;
    assign pauseRename   = robFull || queueBlocked;   // Rename bubbles on its own check.
    assign pauseDispatch = robFull || queueBlocked;

    always_ff @(posedge clk) begin
        if (rst) begin
            outOfReset <= 1'b0;
        end else begin
            outOfReset <= 1'b1;                          // Intake opens one cycle late.
        end
    end

    // ========================================================================
    // Flush fan-out
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            flushDly <= 1'b0;
        end else begin
            flushDly <= flushReq;
        end
    end

    assign backendFlush = flushReq;
    assign robFlush     = flushReq || flushDly;       // No commit while rename recovers.

endmodule

/* logic/backendPkg.sv */
package backendPkg;

    // ========================================================================
    // Functional units
    // ========================================================================

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_LSU,
        UNIT_MDU
    } unitKind;

    // ========================================================================
    // Sizes
    // ========================================================================

    localparam int ARCH_REGS = 8;
    localparam int ARCH_BITS = 3;

    localparam int PHYS_REGS = 16;
    localparam int PHYS_BITS = 4;

    // Physical registers not held by the architectural map at reset.
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;
    localparam int FREE_BITS = 3;

    localparam int ROB_DEPTH = 8;
    localparam int ROB_BITS  = 3;                  // Also the width of a ROB tag.

    localparam int IQ_DEPTH = 4;
    localparam int IQ_BITS  = 2;

endpackage

/* logic/backendTop.sv */
`timescale 1ns/10ps

module backendTop (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             instValid,
    input  backendPkg::unitKind              instKind,
    input  logic [backendPkg::ARCH_BITS-1:0] instDest,
    input  logic                             instMispredict,
    output logic                             instReady,
    input  logic                             aluExecReady,
    input  logic                             lsuExecReady,
    input  logic                             mduExecReady,
    output logic                             aluIssueValid,
    output logic [backendPkg::ROB_BITS-1:0]  aluIssueTag,
    output logic                             lsuIssueValid,
    output logic [backendPkg::ROB_BITS-1:0]  lsuIssueTag,
    output logic                             mduIssueValid,
    output logic [backendPkg::ROB_BITS-1:0]  mduIssueTag,
    output logic                             commitValid,
    output logic [backendPkg::ROB_BITS-1:0]  commitTag,
    output logic [backendPkg::ARCH_BITS-1:0] commitDest,
    output logic [backendPkg::PHYS_BITS-1:0] commitPhys,
    output logic                             backendFlush
);
    import backendPkg::*;

    logic                 pauseIntake, pauseRename, pauseDispatch;
    logic                 flushDly, robFlush, flushReq, robFull;
    logic                 renamePauseReq, renameAllocatable;
    logic                 aluIqReady, lsuIqReady, mduIqReady;
    logic                 intakeValid, intakeMispredict;
    unitKind              intakeKind;
    logic [ARCH_BITS-1:0] intakeDest;
    logic                 dispValid, dispMispredict;
    unitKind              dispKind;
    logic [ARCH_BITS-1:0] dispDest;
    logic [PHYS_BITS-1:0] dispPhys, dispOldPhys, commitOldPhys;
    logic                 allocValid;
    logic [ROB_BITS-1:0]  allocTag;

    // ========================================================================
    // Intake register
    // ========================================================================

    assign instReady = !pauseIntake;

    always_ff @(posedge clk) begin
        if (rst || flushDly) begin
            intakeValid <= 1'b0;
        end else if (!pauseIntake) begin
            intakeValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!pauseIntake) begin
            intakeKind       <= instKind;
            intakeDest       <= instDest;
            intakeMispredict <= instMispredict;
        end
    end

    // ========================================================================
    // Rename, dispatch and routing
    // ========================================================================

    renameStage u_renameStage (
        .clk(clk), .rst(rst), .pause(pauseRename), .recover(flushDly),
        .inValid(intakeValid), .inKind(intakeKind), .inDest(intakeDest),
        .inMispredict(intakeMispredict),
        .outValid(dispValid), .outKind(dispKind), .outDest(dispDest),
        .outPhys(dispPhys), .outOldPhys(dispOldPhys), .outMispredict(dispMispredict),
        .commitValid(commitValid), .commitDest(commitDest), .commitPhys(commitPhys),
        .commitOldPhys(commitOldPhys),
        .allocatable(renameAllocatable), .pauseReq(renamePauseReq)
    );

    assign allocValid = dispValid && !pauseDispatch;  // Held entries are written once.

    issueQueue u_aluQueue (
        .clk(clk), .rst(rst), .flush(flushDly),
        .pushValid(allocValid && dispKind == UNIT_ALU), .pushTag(allocTag),
        .execReady(aluExecReady), .ready(aluIqReady),
        .issueValid(aluIssueValid), .issueTag(aluIssueTag)
    );

    issueQueue u_lsuQueue (
        .clk(clk), .rst(rst), .flush(flushDly),
        .pushValid(allocValid && dispKind == UNIT_LSU), .pushTag(allocTag),
        .execReady(lsuExecReady), .ready(lsuIqReady),
        .issueValid(lsuIssueValid), .issueTag(lsuIssueTag)
    );

    issueQueue u_mduQueue (
        .clk(clk), .rst(rst), .flush(flushDly),
        .pushValid(allocValid && dispKind == UNIT_MDU), .pushTag(allocTag),
        .execReady(mduExecReady), .ready(mduIqReady),
        .issueValid(mduIssueValid), .issueTag(mduIssueTag)
    );

    reorderBuffer u_reorderBuffer (
        .clk(clk), .rst(rst), .flush(robFlush),
        .allocValid(allocValid), .allocDest(dispDest), .allocPhys(dispPhys),
        .allocOldPhys(dispOldPhys), .allocMispredict(dispMispredict),
        .allocTag(allocTag), .full(robFull),
        .aluIssueValid(aluIssueValid), .aluIssueTag(aluIssueTag),
        .lsuIssueValid(lsuIssueValid), .lsuIssueTag(lsuIssueTag),
        .mduIssueValid(mduIssueValid), .mduIssueTag(mduIssueTag),
        .commitValid(commitValid), .commitTag(commitTag), .commitDest(commitDest),
        .commitPhys(commitPhys), .commitOldPhys(commitOldPhys), .flushReq(flushReq)
    );

    backendCtrl u_backendCtrl (
        .clk(clk), .rst(rst), .robFull(robFull),
        .renamePauseReq(renamePauseReq), .renameAllocatable(renameAllocatable),
        .aluIqReady(aluIqReady), .lsuIqReady(lsuIqReady), .mduIqReady(mduIqReady),
        .flushReq(flushReq),
        .pauseIntake(pauseIntake), .pauseRename(pauseRename),
        .pauseDispatch(pauseDispatch), .flushDly(flushDly),
        .robFlush(robFlush), .backendFlush(backendFlush)
    );

endmodule

/* logic/issueQueue.sv */
`timescale 1ns/10ps

module issueQueue (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             pushValid,
    input  logic [backendPkg::ROB_BITS-1:0]  pushTag,
    input  logic                             execReady,
    output logic                             ready,
    output logic                             issueValid,
    output logic [backendPkg::ROB_BITS-1:0]  issueTag
);
    import backendPkg::*;

    logic [ROB_BITS-1:0] tags [IQ_DEPTH];
    logic [IQ_BITS:0]    rdPtr;
    logic [IQ_BITS:0]    wrPtr;
    logic                empty;
    logic                full;
    logic                doPush;

    assign empty  = rdPtr == wrPtr;
    assign full   = (rdPtr[IQ_BITS] != wrPtr[IQ_BITS]) &&
                    (rdPtr[IQ_BITS-1:0] == wrPtr[IQ_BITS-1:0]);
    assign doPush = pushValid && !full;

    assign ready      = !full;
    assign issueValid = !empty && execReady && !flush;   // A dying entry never issues.
    assign issueTag   = tags[rdPtr[IQ_BITS-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (issueValid) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            tags[wrPtr[IQ_BITS-1:0]] <= pushTag;
        end
    end

endmodule

/* logic/renameStage.sv */
`timescale 1ns/10ps

module renameStage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pause,
    input  logic                                 recover,
    input  logic                                 inValid,
    input  backendPkg::unitKind                  inKind,
    input  logic [backendPkg::ARCH_BITS-1:0]     inDest,
    input  logic                                 inMispredict,
    output logic                                 outValid,
    output backendPkg::unitKind                  outKind,
    output logic [backendPkg::ARCH_BITS-1:0]     outDest,
    output logic [backendPkg::PHYS_BITS-1:0]     outPhys,
    output logic [backendPkg::PHYS_BITS-1:0]     outOldPhys,
    output logic                                 outMispredict,
    input  logic                                 commitValid,
    input  logic [backendPkg::ARCH_BITS-1:0]     commitDest,
    input  logic [backendPkg::PHYS_BITS-1:0]     commitPhys,
    input  logic [backendPkg::PHYS_BITS-1:0]     commitOldPhys,
    output logic                                 allocatable,
    output logic                                 pauseReq
);
    import backendPkg::*;

    logic [PHYS_BITS-1:0] specTable   [ARCH_REGS];
    logic [PHYS_BITS-1:0] commitTable [ARCH_REGS];
    logic [PHYS_BITS-1:0] freeRing    [FREE_REGS];
    logic [FREE_BITS:0]   specHead;
    logic [FREE_BITS:0]   commitHead;
    logic [FREE_BITS:0]   tail;
    logic [FREE_BITS-1:0] specIdx;
    logic [FREE_BITS-1:0] tailIdx;
    logic                 doAlloc;

    assign specIdx     = specHead[FREE_BITS-1:0];
    assign tailIdx     = tail[FREE_BITS-1:0];
    assign allocatable = specHead != tail;
    assign pauseReq    = inValid && !allocatable;
    assign doAlloc     = !pause && !recover && inValid && allocatable;

    always_ff @(posedge clk) begin
        if (rst || recover) begin
            outValid <= 1'b0;
        end else if (!pause) begin
            outValid <= inValid && allocatable;      // Bubble when the ring is empty.
        end
    end

    always_ff @(posedge clk) begin
        if (!pause) begin
            outKind       <= inKind;
            outDest       <= inDest;
            outPhys       <= freeRing[specIdx];
            outOldPhys    <= specTable[inDest];
            outMispredict <= inMispredict;
        end
    end

    // ========================================================================
    // Speculative state
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                specTable[r] <= PHYS_BITS'(r);
            end
            specHead <= '0;
        end else if (recover) begin
            specTable <= commitTable;
            specHead  <= commitHead;
        end else if (doAlloc) begin
            specTable[inDest] <= freeRing[specIdx];
            specHead          <= specHead + 1'b1;
        end
    end

    // ========================================================================
    // Committed state and ring refill
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                commitTable[r] <= PHYS_BITS'(r);
            end
            for (int i = 0; i < FREE_REGS; i++) begin
                freeRing[i] <= PHYS_BITS'(ARCH_REGS + i);
            end
            commitHead <= '0;
            tail       <= (FREE_BITS + 1)'(FREE_REGS);   // Ring starts full.
        end else if (commitValid) begin
            commitTable[commitDest] <= commitPhys;
            freeRing[tailIdx]       <= commitOldPhys;  // Previous mapping is free again.
            tail                    <= tail + 1'b1;
            commitHead              <= commitHead + 1'b1;
        end
    end

endmodule

/* logic/reorderBuffer.sv */
`timescale 1ns/10ps

module reorderBuffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             allocValid,
    input  logic [backendPkg::ARCH_BITS-1:0] allocDest,
    input  logic [backendPkg::PHYS_BITS-1:0] allocPhys,
    input  logic [backendPkg::PHYS_BITS-1:0] allocOldPhys,
    input  logic                             allocMispredict,
    output logic [backendPkg::ROB_BITS-1:0]  allocTag,
    output logic                             full,
    input  logic                             aluIssueValid,
    input  logic [backendPkg::ROB_BITS-1:0]  aluIssueTag,
    input  logic                             lsuIssueValid,
    input  logic [backendPkg::ROB_BITS-1:0]  lsuIssueTag,
    input  logic                             mduIssueValid,
    input  logic [backendPkg::ROB_BITS-1:0]  mduIssueTag,
    output logic                             commitValid,
    output logic [backendPkg::ROB_BITS-1:0]  commitTag,
    output logic [backendPkg::ARCH_BITS-1:0] commitDest,
    output logic [backendPkg::PHYS_BITS-1:0] commitPhys,
    output logic [backendPkg::PHYS_BITS-1:0] commitOldPhys,
    output logic                             flushReq
);
    import backendPkg::*;

    logic [ROB_DEPTH-1:0] entValid;
    logic [ROB_DEPTH-1:0] complete;
    logic [ROB_DEPTH-1:0] mispredict;
    logic [ARCH_BITS-1:0] dest    [ROB_DEPTH];
    logic [PHYS_BITS-1:0] phys    [ROB_DEPTH];
    logic [PHYS_BITS-1:0] oldPhys [ROB_DEPTH];
    logic [ROB_BITS:0]    head;
    logic [ROB_BITS:0]    tail;
    logic [ROB_BITS-1:0]  headIdx;
    logic [ROB_BITS-1:0]  tailIdx;
    logic                 doAlloc;

    assign headIdx = head[ROB_BITS-1:0];
    assign tailIdx = tail[ROB_BITS-1:0];
    assign full    = (head[ROB_BITS] != tail[ROB_BITS]) && (headIdx == tailIdx);
    assign doAlloc = allocValid && !full && !flush;

    assign allocTag      = tailIdx;
    assign commitValid   = entValid[headIdx] && complete[headIdx];
    assign commitTag     = headIdx;
    assign commitDest    = dest[headIdx];
    assign commitPhys    = phys[headIdx];
    assign commitOldPhys = oldPhys[headIdx];
    assign flushReq      = commitValid && mispredict[headIdx];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entValid <= '0;
            head     <= '0;
            tail     <= '0;
        end else begin
            if (doAlloc) begin
                entValid[tailIdx] <= 1'b1;
                tail              <= tail + 1'b1;
            end
            if (commitValid) begin
                entValid[headIdx] <= 1'b0;           // Retire the head, one per cycle.
                head              <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doAlloc) begin
            complete[tailIdx]   <= 1'b0;
            mispredict[tailIdx] <= allocMispredict;
            dest[tailIdx]       <= allocDest;
            phys[tailIdx]       <= allocPhys;
            oldPhys[tailIdx]    <= allocOldPhys;
        end
        if (aluIssueValid) complete[aluIssueTag] <= 1'b1;
        if (lsuIssueValid) complete[lsuIssueTag] <= 1'b1;
        if (mduIssueValid) complete[mduIssueTag] <= 1'b1;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the backend testbench with Verilator, runs it, and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module backendTb -f files.f -o simBackend \
    && ./obj_dir/simBackend | tee sim.log \
    && grep -q "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
